/* src/lsuPkg.sv */
package lsuPkg;

    // Datapath widths
    localparam int dataWidth = 16;
    localparam int regAddrWidth = 4;
    localparam int opcodeWidth = 4;
    localparam int flashAddrWidth = 10;

    // Minor opcodes of the load/store unit
    localparam logic [opcodeWidth-1:0] opLoad = 4'd0;
    localparam logic [opcodeWidth-1:0] opStore = 4'd1;

    // Address bit that moves a request from fixed memory to the IO port
    localparam int ioSelectBit = 15;

    // Queued load/store request of 40 bits
    typedef struct packed {
        logic [opcodeWidth-1:0]  opcode;
        logic [dataWidth-1:0]    address;
        logic [dataWidth-1:0]    storeValue;
        logic [regAddrWidth-1:0] destReg;
    } lsuRequest;

    // Register write of 20 bits produced by a load
    typedef struct packed {
        logic [regAddrWidth-1:0] destReg;
        logic [dataWidth-1:0]    data;
    } writebackEntry;

    // True when the address belongs to the IO port
    function automatic logic isIoAddress(input logic [dataWidth-1:0] address);
        return address[ioSelectBit];
    endfunction

    // Anything that is not a store is handled as a load
    function automatic logic isStoreOp(input logic [opcodeWidth-1:0] opcode);
        return opcode == opStore;
    endfunction

endpackage

/* src/handshakeFifo.sv */
`timescale 1ns/1ps

module handshakeFifo #(
    parameter int depth = 4,
    parameter type payloadType = logic [7:0]
) (
    input  logic       clk,
    input  logic       reset,

    // Write side where this queue is the receiver
    output logic       inReq,
    input  logic       inAck,
    input  payloadType inData,

    // Read side where this queue is the sender
    input  logic       outReq,
    output logic       outAck,
    output payloadType outData
);
    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam int countWidth = $clog2(depth + 1);
    localparam logic [ptrWidth-1:0] lastSlot = ptrWidth'(depth - 1);
    localparam logic [countWidth-1:0] fullCount = countWidth'(depth);

    payloadType storage [depth];
    logic [ptrWidth-1:0]   writePtr;
    logic [ptrWidth-1:0]   readPtr;
    logic [countWidth-1:0] count;
    logic                  pushEn;
    logic                  popEn;

    // Space left and item available
    assign inReq = (count != fullCount);
    assign outAck = (count != '0);
    assign outData = storage[readPtr];

    assign pushEn = inReq && inAck;
    assign popEn = outReq && outAck;

    always_ff @(posedge clk) begin
        if (pushEn) begin
            storage[writePtr] <= inData;
        end
    end

    // Pointers wrap at the last slot so any depth works
    always_ff @(posedge clk) begin
        if (reset) begin
            writePtr <= '0;
            readPtr <= '0;
            count <= '0;
        end else begin
            if (pushEn) begin
                writePtr <= (writePtr == lastSlot) ? '0 : writePtr + ptrWidth'(1);
            end
            if (popEn) begin
                readPtr <= (readPtr == lastSlot) ? '0 : readPtr + ptrWidth'(1);
            end
            // Push and pop in the same cycle leave the count alone
            if (pushEn && !popEn) begin
                count <= count + countWidth'(1);
            end else if (popEn && !pushEn) begin
                count <= count - countWidth'(1);
            end
        end
    end

endmodule

/* src/loadStoreRouter.sv */
`timescale 1ns/1ps

module loadStoreRouter (
    // Head of the request queue
    output logic                             reqReq,
    input  logic                             reqAck,
    input  lsuPkg::lsuRequest                request,

    // Fixed memory side
    input  logic                             memReq,
    output logic                             memAck,
    output lsuPkg::lsuRequest                memRequest,

    // IO-out port
    input  logic                             ioOutReq,
    output logic                             ioOutAck,
    output logic [lsuPkg::opcodeWidth-1:0]   ioOutOpcode,
    output logic [lsuPkg::dataWidth-1:0]     ioOutAddress,
    output logic [lsuPkg::dataWidth-1:0]     ioOutData,
    output logic [lsuPkg::regAddrWidth-1:0]  ioOutDestReg
);
    logic toIo;

    // Only place where the IO address range is decoded
    assign toIo = lsuPkg::isIoAddress(request.address);

    // Valid goes to one side only
    assign memAck = reqAck && !toIo;
    assign ioOutAck = reqAck && toIo;

    // The queue head sees the selected side's readiness
    assign reqReq = toIo ? ioOutReq : memReq;

    assign memRequest = request;

    // IO port gets the request fields unchanged
    assign ioOutOpcode = request.opcode;
    assign ioOutAddress = request.address;
    assign ioOutData = request.storeValue;
    assign ioOutDestReg = request.destReg;

endmodule

/* src/fixedMemory.sv */
`timescale 1ns/1ps

module fixedMemory #(
    parameter int memAddrWidth = 10
) (
    input  logic                              clk,
    input  logic                              reset,

    // Flash port overrides any request
    input  logic                              flashEn,
    input  logic [lsuPkg::flashAddrWidth-1:0] flashAddr,
    input  logic [lsuPkg::dataWidth-1:0]      flashData,

    // Requests from the router
    output logic                              reqReq,
    input  logic                              reqAck,
    input  lsuPkg::lsuRequest                 request,

    // Load results towards the writeback queue
    input  logic                              wbReq,
    output logic                              wbAck,
    output lsuPkg::writebackEntry             wbData
);
    localparam int memWords = 2 ** memAddrWidth;

    logic [lsuPkg::dataWidth-1:0] memory [memWords];
    logic [memAddrWidth-1:0]      wordAddr;
    logic [memAddrWidth-1:0]      flashWord;
    logic                         isStore;
    logic                         accept;
    logic                         storeEn;
    logic                         loadEn;
    logic                         resultValid;

    // Word index from the low address bits
    assign wordAddr = request.address[memAddrWidth-1:0];
    assign flashWord = flashAddr[memAddrWidth-1:0];
    assign isStore = lsuPkg::isStoreOp(request.opcode);

    // Stores only need the array while a load also needs a free result slot
    assign reqReq = !flashEn && (isStore || !resultValid);
    assign accept = reqReq && reqAck;
    assign storeEn = accept && isStore;
    assign loadEn = accept && !isStore;

    always_ff @(posedge clk) begin
        if (flashEn) begin
            memory[flashWord] <= flashData;
        end else if (storeEn) begin
            memory[wordAddr] <= request.storeValue;
        end
    end

    // Result slot holds the read word until the writeback queue takes it
    always_ff @(posedge clk) begin
        if (loadEn) begin
            wbData.destReg <= request.destReg;
            wbData.data <= memory[wordAddr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
        end else if (loadEn) begin
            resultValid <= 1'b1;
        end else if (wbReq && resultValid) begin
            resultValid <= 1'b0;
        end
    end

    assign wbAck = resultValid;

endmodule

/* src/memWritebackArbiter.sv */
`timescale 1ns/1ps

module memWritebackArbiter (
    input  logic                             clk,
    input  logic                             reset,

    // Memory writeback queue
    output logic                             memReq,
    input  logic                             memAck,
    input  lsuPkg::writebackEntry            memEntry,

    // IO-in port
    output logic                             ioInReq,
    input  logic                             ioInAck,
    input  logic [lsuPkg::regAddrWidth-1:0]  ioInDestReg,
    input  logic [lsuPkg::dataWidth-1:0]     ioInData,

    // Register write port
    output logic                             regWriteEn,
    output logic [lsuPkg::regAddrWidth-1:0]  regWriteAddr,
    output logic [lsuPkg::dataWidth-1:0]     regWriteData
);
    logic memGrant;
    logic ioGrant;

    // Memory wins and IO goes only when the memory queue is empty
    assign memGrant = memAck;
    assign ioGrant = ioInAck && !memAck;

    // Ready is shown to the granted side only
    assign memReq = memGrant;
    assign ioInReq = ioGrant;

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteEn <= 1'b0;
        end else begin
            regWriteEn <= memGrant || ioGrant;
        end
    end

    // Write address and data follow the winner of this cycle
    always_ff @(posedge clk) begin
        if (memGrant) begin
            regWriteAddr <= memEntry.destReg;
            regWriteData <= memEntry.data;
        end else if (ioGrant) begin
            regWriteAddr <= ioInDestReg;
            regWriteData <= ioInData;
        end
    end

endmodule

/* src/loadStoreTop.sv */
`timescale 1ns/1ps

module loadStoreTop #(
    parameter int requestDepth = 4,
    parameter int writebackDepth = 4,
    parameter int memAddrWidth = 10
) (
    input  logic                              clk,
    input  logic                              reset,

    // Request port
    output logic                              lsReq,
    input  logic                              lsAck,
    input  logic [lsuPkg::opcodeWidth-1:0]    lsOpcode,
    input  logic [lsuPkg::dataWidth-1:0]      lsAddress,
    input  logic [lsuPkg::dataWidth-1:0]      lsStoreValue,
    input  logic [lsuPkg::regAddrWidth-1:0]   lsDestReg,

    // IO-out port
    input  logic                              ioOutReq,
    output logic                              ioOutAck,
    output logic [lsuPkg::opcodeWidth-1:0]    ioOutOpcode,
    output logic [lsuPkg::dataWidth-1:0]      ioOutAddress,
    output logic [lsuPkg::dataWidth-1:0]      ioOutData,
    output logic [lsuPkg::regAddrWidth-1:0]   ioOutDestReg,

    // IO-in port
    output logic                              ioInReq,
    input  logic                              ioInAck,
    input  logic [lsuPkg::regAddrWidth-1:0]   ioInDestReg,
    input  logic [lsuPkg::dataWidth-1:0]      ioInData,

    // Flash port
    input  logic                              flashEn,
    input  logic [lsuPkg::flashAddrWidth-1:0] flashAddr,
    input  logic [lsuPkg::dataWidth-1:0]      flashData,

    // Register write port
    output logic                              regWriteEn,
    output logic [lsuPkg::regAddrWidth-1:0]   regWriteAddr,
    output logic [lsuPkg::dataWidth-1:0]      regWriteData
);
    lsuPkg::lsuRequest     lsRequest;
    lsuPkg::lsuRequest     headRequest;
    lsuPkg::lsuRequest     memRequest;
    lsuPkg::writebackEntry memResult;
    lsuPkg::writebackEntry wbHead;
    logic                  headReq;
    logic                  headAck;
    logic                  memReq;
    logic                  memAck;
    logic                  resultReq;
    logic                  resultAck;
    logic                  wbHeadReq;
    logic                  wbHeadAck;

    assign lsRequest = '{
        opcode:     lsOpcode,
        address:    lsAddress,
        storeValue: lsStoreValue,
        destReg:    lsDestReg
    };

    handshakeFifo #(
        .depth      (requestDepth),
        .payloadType(lsuPkg::lsuRequest)
    ) requestQueue (
        .clk    (clk),
        .reset  (reset),
        .inReq  (lsReq),
        .inAck  (lsAck),
        .inData (lsRequest),
        .outReq (headReq),
        .outAck (headAck),
        .outData(headRequest)
    );

    loadStoreRouter router (
        .reqReq      (headReq),
        .reqAck      (headAck),
        .request     (headRequest),
        .memReq      (memReq),
        .memAck      (memAck),
        .memRequest  (memRequest),
        .ioOutReq    (ioOutReq),
        .ioOutAck    (ioOutAck),
        .ioOutOpcode (ioOutOpcode),
        .ioOutAddress(ioOutAddress),
        .ioOutData   (ioOutData),
        .ioOutDestReg(ioOutDestReg)
    );

    fixedMemory #(
        .memAddrWidth(memAddrWidth)
    ) dataMemory (
        .clk      (clk),
        .reset    (reset),
        .flashEn  (flashEn),
        .flashAddr(flashAddr),
        .flashData(flashData),
        .reqReq   (memReq),
        .reqAck   (memAck),
        .request  (memRequest),
        .wbReq    (resultReq),
        .wbAck    (resultAck),
        .wbData   (memResult)
    );

    // Load results wait here while IO-in or the arbiter is busy
    handshakeFifo #(
        .depth      (writebackDepth),
        .payloadType(lsuPkg::writebackEntry)
    ) writebackQueue (
        .clk    (clk),
        .reset  (reset),
        .inReq  (resultReq),
        .inAck  (resultAck),
        .inData (memResult),
        .outReq (wbHeadReq),
        .outAck (wbHeadAck),
        .outData(wbHead)
    );

    memWritebackArbiter arbiter (
        .clk         (clk),
        .reset       (reset),
        .memReq      (wbHeadReq),
        .memAck      (wbHeadAck),
        .memEntry    (wbHead),
        .ioInReq     (ioInReq),
        .ioInAck     (ioInAck),
        .ioInDestReg (ioInDestReg),
        .ioInData    (ioInData),
        .regWriteEn  (regWriteEn),
        .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData)
    );

endmodule

/* testbench/loadStoreTb_assert.sv */
`timescale 1ns/1ps

module handshakeAssertions (
    input logic        clk,
    input logic        reset,
    input logic        lsReq,
    input logic        ioOutReq,
    input logic        ioOutAck,
    input logic [39:0] ioOutPayload,
    input logic        writeGrant,
    input logic        regWriteEn
);
    int holdFailures = 0;
    int writeFailures = 0;
    int resetFailures = 0;
    int failureCount;

    assign failureCount = holdFailures + writeFailures + resetFailures;

    // A stalled IO-out request keeps its valid and its fields
    ioOutHeld: assert property (@(posedge clk) disable iff (reset)
        ioOutAck && !ioOutReq |=> ioOutAck && $stable(ioOutPayload))
        else begin
            holdFailures++;
            $error("IO-out request changed before the device took it");
        end

    // One write per accepted entry and never unknown
    writePulse: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(regWriteEn) && (!regWriteEn || $past(writeGrant)))
        else begin
            writeFailures++;
            $error("regWriteEn unknown or without an accepted entry");
        end

    readyAfterReset: assert property (@(posedge clk) $fell(reset) |-> lsReq)
        else begin
            resetFailures++;
            $error("lsReq not high after reset");
        end

endmodule

bind loadStoreTop handshakeAssertions assertChecks (
    .clk         (clk),
    .reset       (reset),
    .lsReq       (lsReq),
    .ioOutReq    (ioOutReq),
    .ioOutAck    (ioOutAck),
    .ioOutPayload({ioOutOpcode, ioOutAddress, ioOutData, ioOutDestReg}),
    .writeGrant  ((wbHeadReq && wbHeadAck) || (ioInReq && ioInAck)),
    .regWriteEn  (regWriteEn)
);

/* testbench/loadStoreTb.sv */
`timescale 1ns/1ps

module loadStoreTb;
    localparam int clockPeriod = 100;
    localparam int resetCycles = 5;
    localparam int requestDepth = 4;
    localparam int numTests = 6;
    localparam int maxTransfers = 60;
    localparam int cyclesPerTransfer = 10;
    // Every test bounded by its transfers plus reset and idle gaps
    localparam int timeoutCycles = numTests * maxTransfers * cyclesPerTransfer + 400;
    localparam logic [15:0] ioResponseMask = 16'h5a5a;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic lsAck = 1'b0;
    logic ioOutReq = 1'b0;
    logic ioInAck = 1'b0;
    logic flashEn = 1'b0;
    logic lsReq;
    logic ioOutAck;
    logic ioInReq;
    logic regWriteEn;
    logic [3:0] lsOpcode = '0;
    logic [3:0] lsDestReg = '0;
    logic [3:0] ioInDestReg = '0;
    logic [15:0] lsAddress = '0;
    logic [15:0] lsStoreValue = '0;
    logic [15:0] ioInData = '0;
    logic [15:0] flashData = '0;
    logic [9:0] flashAddr = '0;
    logic [3:0] ioOutOpcode;
    logic [3:0] ioOutDestReg;
    logic [3:0] regWriteAddr;
    logic [15:0] ioOutAddress;
    logic [15:0] ioOutData;
    logic [15:0] regWriteData;

    logic [31:0] lfsrState = 32'hbf41_9a7a;
    logic [15:0] mirror [1024];
    logic [15:0] addressList [$];
    logic [19:0] memExpected [$];
    logic [19:0] ioExpected [$];
    logic [39:0] ioOutExpected [$];
    logic [19:0] ioPending [$];
    logic [19:0] actualWrite;
    logic [39:0] actualIoOut;
    logic ioStall = 1'b0;
    string testName = "resetState";
    int mainErrors = 0;
    int writeErrors = 0;
    int ioErrors = 0;
    int testStartErrors = 0;
    int testsRun = 0;
    int issued = 0;
    int cycles = 0;

    loadStoreTop #(.requestDepth(requestDepth)) UUT (.*);

    always #(clockPeriod / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("Timeout after %0d cycles in %s", cycles, testName);
            $display("Test failed");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [15:0] randomBits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[14:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [3:0] randomOpcode();
        return (randomBits(1) != 16'd0) ? lsuPkg::opStore : lsuPkg::opLoad;
    endfunction

    // Expected register write of a load, from the IO rule or the mirror
    function automatic logic [19:0] expectedWrite(input logic [15:0] address,
                                                  input logic [3:0] destReg);
        if (address[15]) begin
            return {destReg, address ^ ioResponseMask};
        end
        return {destReg, mirror[address[9:0]]};
    endfunction

    function automatic int compareValue(input string what, input logic [39:0] expected,
                                        input logic [39:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s %s expected %h actual %h", testName, what, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    function automatic int totalErrors();
        return mainErrors + writeErrors + ioErrors + UUT.assertChecks.failureCount;
    endfunction

    // Starts at a falling edge and returns at the falling edge after the transfer
    task automatic sendRequest(input logic [3:0] opcode, input logic [15:0] address,
                               input logic [15:0] value);
        lsAck = 1'b1;
        lsOpcode = opcode;
        lsAddress = address;
        lsStoreValue = value;
        lsDestReg = 4'(randomBits(4));
        // lsReq only changes at rising edges
        while (!lsReq) begin
            @(negedge clk);
        end
        if (address[15]) begin
            ioOutExpected.push_back({opcode, address, value, lsDestReg});
        end else if (opcode == lsuPkg::opStore) begin
            mirror[address[9:0]] = value;
        end
        if (opcode != lsuPkg::opStore && address[15]) begin
            ioExpected.push_back(expectedWrite(address, lsDestReg));
        end else if (opcode != lsuPkg::opStore) begin
            memExpected.push_back(expectedWrite(address, lsDestReg));
        end
        @(negedge clk);
        lsAck = 1'b0;
    endtask

    task automatic drainAndReport();
        while (memExpected.size() + ioExpected.size() + ioOutExpected.size() != 0) begin
            @(negedge clk);
        end
        // Idle cycles so a stray register write is still caught
        repeat (4) @(negedge clk);
        testsRun++;
        $display("%s done with %0d errors", testName, totalErrors() - testStartErrors);
        testStartErrors = totalErrors();
    endtask

    // IO device model answering loads in order with address XOR mask
    always @(negedge clk) begin
        ioOutReq = !reset && !ioStall;
        ioInAck = !reset && ioPending.size() != 0;
        if (ioInAck) begin
            ioInDestReg = ioPending[0][19:16];
            ioInData = ioPending[0][15:0];
        end
        // ioInReq follows ioInAck combinationally
        #1;
        if (ioOutReq && ioOutAck) begin
            actualIoOut = {ioOutOpcode, ioOutAddress, ioOutData, ioOutDestReg};
            if (ioOutExpected.size() == 0) begin
                ioErrors++;
                $display("IO-out sent address %h that was never requested", ioOutAddress);
            end else begin
                ioErrors += compareValue("IO-out request", ioOutExpected.pop_front(),
                                         actualIoOut);
            end
            if (ioOutOpcode != lsuPkg::opStore) begin
                ioPending.push_back({ioOutDestReg, ioOutAddress ^ ioResponseMask});
            end
        end
        if (ioInAck && ioInReq) begin
            void'(ioPending.pop_front());
        end
    end

    // Each source stays in order so a write matches the head of one stream
    always @(negedge clk) begin
        if (!reset && regWriteEn) begin
            actualWrite = {regWriteAddr, regWriteData};
            if (memExpected.size() != 0 &&
                (memExpected[0] == actualWrite || ioExpected.size() == 0)) begin
                writeErrors += compareValue("memory load", 40'(memExpected.pop_front()),
                                            40'(actualWrite));
            end else if (ioExpected.size() != 0) begin
                writeErrors += compareValue("IO load", 40'(ioExpected.pop_front()),
                                            40'(actualWrite));
            end else begin
                writeErrors++;
                $display("Register write r%0d = %h with no load outstanding",
                         regWriteAddr, regWriteData);
            end
        end
    end

    initial begin
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
        mainErrors += compareValue("regWriteEn", 40'd0, 40'(regWriteEn));
        mainErrors += compareValue("ioOutAck", 40'd0, 40'(ioOutAck));
        mainErrors += compareValue("ioInReq", 40'd0, 40'(ioInReq));
        @(negedge clk);
        mainErrors += compareValue("lsReq", 40'd1, 40'(lsReq));
        drainAndReport();

        testName = "flashThenLoad";
        for (int i = 0; i < 16; i++) begin
            addressList.push_back(randomBits(10));
            flashEn = 1'b1;
            flashAddr = 10'(addressList[i]);
            flashData = randomBits(16);
            mirror[flashAddr] = flashData;
            @(negedge clk);
        end
        flashEn = 1'b0;
        foreach (addressList[i]) sendRequest(lsuPkg::opLoad, addressList[i], randomBits(16));
        drainAndReport();

        testName = "storeThenLoad";
        addressList.delete();
        for (int i = 0; i < 16; i++) begin
            addressList.push_back(randomBits(15));
            sendRequest(lsuPkg::opStore, addressList[i], randomBits(16));
        end
        foreach (addressList[i]) sendRequest(lsuPkg::opLoad, addressList[i], 16'd0);
        drainAndReport();

        testName = "ioRequests";
        for (int i = 0; i < 16; i++) begin
            sendRequest(randomOpcode(), 16'h8000 | randomBits(15), randomBits(16));
        end
        drainAndReport();

        testName = "mixedLoads";
        for (int i = 0; i < 24; i++) begin
            if (randomBits(1) != 16'd0) begin
                sendRequest(lsuPkg::opLoad, 16'h8000 | randomBits(15), 16'd0);
            end else begin
                sendRequest(lsuPkg::opLoad, addressList[randomBits(4)], 16'd0);
            end
        end
        drainAndReport();

        testName = "backPressure";
        ioStall = 1'b1;
        @(negedge clk);
        while (lsReq) begin
            sendRequest(lsuPkg::opLoad, 16'h8000 | randomBits(15), 16'd0);
            issued++;
        end
        repeat (4) @(negedge clk);
        mainErrors += compareValue("requests taken while stalled", 40'(requestDepth), 40'(issued));
        mainErrors += compareValue("lsReq while stalled", 40'd0, 40'(lsReq));
        ioStall = 1'b0;
        for (int i = 0; i < 8; i++) begin
            sendRequest(lsuPkg::opLoad, addressList[randomBits(4)], 16'd0);
        end
        drainAndReport();

        $display("Tests run %0d, errors %0d", testsRun, totalErrors());
        if (totalErrors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/lsuPkg.sv
src/handshakeFifo.sv
src/loadStoreRouter.sv
src/fixedMemory.sv
src/memWritebackArbiter.sv
src/loadStoreTop.sv
testbench/loadStoreTb_assert.sv
testbench/loadStoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the load/store testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module loadStoreTb -f filelist.f -Mdir obj_dir

output=$(./obj_dir/VloadStoreTb +verilator+error+limit+1000)
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
    exit 0
else
    exit 1
fi
